/* rtl/drp_cfg.svh */
`ifndef DRP_CFG_SVH
`define DRP_CFG_SVH

// Shape of the one junction this generator serves

// Each input neuron fans out to this many weights
`define DRP_FO 2

// Input neurons of the junction
`define DRP_P 16

// Parallel lanes, one address each per processing cycle
`define DRP_Z 8

// Dither width per lane, equal to Z / FO
`define DRP_M 4

// Seed values loaded by reset
`define DRP_SEED_S_RST 3  // Start offset of the relatively prime step
`define DRP_SEED_P_RST 23 // Multiplier, odd so the step is a permutation of the 32 weights

`endif

/* rtl/drp_pkg.sv */
`default_nettype none

`include "drp_cfg.svh"

// Vector types used by the address arithmetic of every lane
package drp_pkg;

	// Cycle number within one junction, FO*P/Z cycles in total
	typedef logic [$clog2(`DRP_FO*`DRP_P/`DRP_Z)-1:0] cycle_idx_t;

	// Index over all FO*P weights
	// It also carries the lane tagged value and each stage result of the interleaver
	typedef logic [$clog2(`DRP_FO*`DRP_P)-1:0] weight_idx_t;

	typedef logic [$clog2(`DRP_P)-1:0] neuron_idx_t; // One of the P input neurons

	// All lane addresses of one cycle, lane k sits in element k
	typedef neuron_idx_t [`DRP_Z-1:0] lane_addr_vec_t;

endpackage

`default_nettype wire

/* rtl/junction_pkg.sv */
`default_nettype none

// Types for the run-time side of the junction, its seed and its request control
package junction_pkg;

	// Seed of the relatively prime step, written through the configuration port
	typedef struct packed {
		drp_pkg::weight_idx_t start; // Offset added after the multiply
		drp_pkg::weight_idx_t mult;  // Should be odd to give a permutation
	} drp_seed_t;

	// Request controller states
	typedef enum logic [1:0] {
		IDLE, // Waiting for req
		CALC, // Lanes settle on the captured cycle, results get registered
		HOLD  // ack high until req goes away
	} ctrl_state_t;

endpackage

`default_nettype wire

/* rtl/drp_seed_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "drp_cfg.svh"

// Holds the start offset and the multiplier that steer every lane
// A write loads both fields together on the next clock edge
module drp_seed_regs (
	input  wire                     clk,
	input  wire                     arst_n_i,
	input  wire                     seed_we_i,
	input  wire junction_pkg::drp_seed_t seed_i,
	output junction_pkg::drp_seed_t seed_o
);

	// Values the interleaver comes up with
	localparam junction_pkg::drp_seed_t SEED_RST = '{
		start: drp_pkg::weight_idx_t'(`DRP_SEED_S_RST),
		mult:  drp_pkg::weight_idx_t'(`DRP_SEED_P_RST)
	};

	junction_pkg::drp_seed_t seed_q;

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			seed_q <= SEED_RST;
		end else if (seed_we_i) begin
			seed_q <= seed_i; // Takes effect for any request whose CALC comes later
		end
	end

	// Lanes see the stored seed directly
	assign seed_o = seed_q;

endmodule

`default_nettype wire

/* rtl/drp_lane.sv */
`timescale 1ns/1ps
`default_nettype none

`include "drp_cfg.svh"

// One purely combinational DRP interleaver lane
// Read dither, relatively prime step, then write dither
module drp_lane #(
	parameter int unsigned LANE = 0
) (
	input  wire drp_pkg::cycle_idx_t      cycle_idx_i,
	input  wire junction_pkg::drp_seed_t  seed_i,
	output drp_pkg::neuron_idx_t          neuron_o
);

	localparam int WEIGHT_W = $bits(drp_pkg::weight_idx_t);
	localparam int NEURON_W = $bits(drp_pkg::neuron_idx_t);
	localparam int LANE_W   = $clog2(`DRP_Z);
	localparam int DITHER_W = $clog2(`DRP_M); // Low bits reordered by both dithers

	localparam logic [LANE_W-1:0] LANE_ID = LANE_W'(LANE);

	drp_pkg::weight_idx_t tagged_val; // Cycle on top, lane number below
	drp_pkg::weight_idx_t r_val;      // After the read dither
	drp_pkg::weight_idx_t rp_val;     // After the relatively prime step
	drp_pkg::weight_idx_t w_val;      // After the write dither

	// Dither vector {1,2,3,0} on the low bits while the upper bits pass through
	// Read and write dither share the same vector at this size
	function automatic drp_pkg::weight_idx_t dither(input drp_pkg::weight_idx_t val);
		logic [DITHER_W-1:0] d;
		case (val[DITHER_W-1:0])
			2'd0: d = 2'd1;
			2'd1: d = 2'd2;
			2'd2: d = 2'd3;
			default: d = 2'd0;
		endcase
		return {val[WEIGHT_W-1:DITHER_W], d};
	endfunction

	assign tagged_val = {cycle_idx_i, LANE_ID};

	// Stage 1
	assign r_val = dither(tagged_val);

	// Stage 2 lets the 5 bit result wrap modulo the 32 weights
	assign rp_val = drp_pkg::weight_idx_t'(seed_i.start + r_val * seed_i.mult);

	// Stage 3
	assign w_val = dither(rp_val);

	assign neuron_o = w_val[NEURON_W-1:0]; // The top bit only picks the fan-out copy

endmodule

`default_nettype wire

/* rtl/drp_req_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

// Four-phase req/ack front end of the generator
// IDLE captures the cycle index, CALC registers the lane results, HOLD keeps them until req drops
module drp_req_ctrl (
	input  wire                          clk,
	input  wire                          arst_n_i,
	input  wire                          req_i,
	input  wire drp_pkg::cycle_idx_t     cycle_idx_i,
	input  wire drp_pkg::lane_addr_vec_t lane_addr_i,
	output drp_pkg::cycle_idx_t          lane_cycle_o,
	output logic                         ack_o,
	output drp_pkg::lane_addr_vec_t      addr_o
);

	junction_pkg::ctrl_state_t state_q, state_d;

	drp_pkg::cycle_idx_t     cycle_q; // Cycle index of the request in flight
	drp_pkg::lane_addr_vec_t addr_q;
	logic                    ack_q;

	always_comb begin
		state_d = state_q;
		case (state_q)
			junction_pkg::IDLE: begin
				if (req_i) state_d = junction_pkg::CALC;
			end
			junction_pkg::CALC: state_d = junction_pkg::HOLD; // One cycle for the lanes to settle
			junction_pkg::HOLD: begin
				if (!req_i) state_d = junction_pkg::IDLE;
			end
			default: state_d = junction_pkg::IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q <= junction_pkg::IDLE;
			ack_q   <= 1'b0;
			addr_q  <= '0;
		end else begin
			state_q <= state_d;
			if (state_q == junction_pkg::CALC) begin
				addr_q <= lane_addr_i; // Seed and cycle are both stable here
				ack_q  <= 1'b1;
			end else if (state_q == junction_pkg::HOLD && !req_i) begin
				ack_q <= 1'b0;
			end
		end
	end

	// Taken once per request as the FSM leaves IDLE
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			cycle_q <= '0;
		end else if (state_q == junction_pkg::IDLE && req_i) begin
			cycle_q <= cycle_idx_i;
		end
	end

	assign lane_cycle_o = cycle_q;
	assign ack_o        = ack_q;
	assign addr_o       = addr_q;

endmodule

`default_nettype wire

/* rtl/drp_addr_gen.sv */
`timescale 1ns/1ps
`default_nettype none

`include "drp_cfg.svh"

// DRP address generator for one sparse junction
// Returns the Z neuron indices of a processing cycle through a req/ack handshake
module drp_addr_gen (
	input  wire                          clk,
	input  wire                          arst_n_i,
	input  wire                          seed_we_i,
	input  wire junction_pkg::drp_seed_t seed_i,
	input  wire                          req_i,
	input  wire drp_pkg::cycle_idx_t     cycle_idx_i,
	output logic                         ack_o,
	output drp_pkg::lane_addr_vec_t      addr_o
);

	junction_pkg::drp_seed_t seed;       // Current start and multiplier
	drp_pkg::cycle_idx_t     lane_cycle; // Captured cycle index, shared by all lanes
	drp_pkg::lane_addr_vec_t lane_addr;  // Combinational lane results

	drp_seed_regs seed_regs_inst (
		.clk       (clk),
		.arst_n_i  (arst_n_i),
		.seed_we_i (seed_we_i),
		.seed_i    (seed_i),
		.seed_o    (seed)
	);

	drp_req_ctrl req_ctrl_inst (
		.clk          (clk),
		.arst_n_i     (arst_n_i),
		.req_i        (req_i),
		.cycle_idx_i  (cycle_idx_i),
		.lane_addr_i  (lane_addr),
		.lane_cycle_o (lane_cycle),
		.ack_o        (ack_o),
		.addr_o       (addr_o)
	);

	// One interleaver per lane, each with its own fixed lane number
	for (genvar gv_i = 0; gv_i < `DRP_Z; gv_i++) begin : g_lane
		drp_lane #(
			.LANE (gv_i)
		) lane_inst (
			.cycle_idx_i (lane_cycle),
			.seed_i      (seed),
			.neuron_o    (lane_addr[gv_i])
		);
	end

endmodule

`default_nettype wire

/* dv/drp_addr_gen_checker.sv */
`timescale 1ns/1ps
`default_nettype none

// Handshake and reset properties of the DRP address generator, bound into drp_addr_gen
module drp_addr_gen_checker (
	input wire                          clk,
	input wire                          arst_n_i,
	input wire                          req_i,
	input wire                          ack_i,
	input wire drp_pkg::lane_addr_vec_t addr_i
);

	int unsigned assert_fail_cnt = 0; // Assertion failures seen so far

	// ack stays low while reset is applied and on the first edge after release
	a_ack_reset: assert property (@(posedge clk)
		(!arst_n_i || !$past(arst_n_i)) |-> !ack_i)
		else begin $error("ack_o high during or right after reset"); assert_fail_cnt++; end

	a_ack_rise: assert property (@(posedge clk) disable iff (!arst_n_i)
		$rose(req_i) |-> ##2 $rose(ack_i))
		else begin $error("ack_o did not rise 2 cycles after req_i"); assert_fail_cnt++; end

	// No ack without a request two samples earlier
	a_ack_cause: assert property (@(posedge clk) disable iff (!arst_n_i)
		$rose(ack_i) |-> $past($rose(req_i), 2))
		else begin $error("ack_o rose without a matching req_i"); assert_fail_cnt++; end

	a_ack_fall: assert property (@(posedge clk) disable iff (!arst_n_i)
		$fell(req_i) |-> ##1 $fell(ack_i))
		else begin $error("ack_o did not fall 1 cycle after req_i"); assert_fail_cnt++; end

	a_addr_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
		(ack_i && $past(ack_i)) |-> $stable(addr_i))
		else begin $error("addr_o changed while ack_o was high"); assert_fail_cnt++; end

endmodule

`default_nettype wire

/* dv/drp_addr_gen_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "drp_cfg.svh"

module drp_addr_gen_tb;

	localparam int N_REQ           = 58; // 4 reset seed, 24 permutation, 20 reconfig, 10 hold
	localparam int WATCHDOG_CYCLES = N_REQ * 10 + 200;
	localparam int ACK_WAIT_MAX    = 8;

	logic                    clk;
	logic                    arst_n_i;
	logic                    seed_we_i;
	junction_pkg::drp_seed_t seed_i;
	logic                    req_i;
	drp_pkg::cycle_idx_t     cycle_idx_i;
	logic                    ack_o;
	drp_pkg::lane_addr_vec_t addr_o;

	junction_pkg::drp_seed_t cur_seed;      // Seed the DUT holds after the last write
	int                      exp_cycle_q[$]; // Requests waiting for their ack
	junction_pkg::drp_seed_t exp_seed_q[$];
	logic                    ack_seen = 1'b0;
	logic [31:0]             lcg_state = 32'd891;

	drp_addr_gen drp_addr_gen_inst (
		.clk         (clk),
		.arst_n_i    (arst_n_i),
		.seed_we_i   (seed_we_i),
		.seed_i      (seed_i),
		.req_i       (req_i),
		.cycle_idx_i (cycle_idx_i),
		.ack_o       (ack_o),
		.addr_o      (addr_o)
	);

	bind drp_addr_gen drp_addr_gen_checker checker_inst (
		.clk      (clk),
		.arst_n_i (arst_n_i),
		.req_i    (req_i),
		.ack_i    (ack_o),
		.addr_i   (addr_o)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic int rand_below(input int n);
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return int'(lcg_state[31:16]) % n; // Upper bits have the longer period
	endfunction

	// Expected neuron of one lane by the three stage DRP rule
	function automatic int ref_neuron(input int cyc, input int lane, input int start, input int mult);
		int v;
		int r;
		int w;
		v = cyc * `DRP_Z + lane;
		v = (v / `DRP_M) * `DRP_M + (v + 1) % `DRP_M;  // Read dither
		r = (start + v * mult) % (`DRP_FO * `DRP_P);
		w = (r / `DRP_M) * `DRP_M + (r + 1) % `DRP_M;  // Write dither
		return w % `DRP_P;
	endfunction

	task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			$display("[ERROR] %0t ns: %s, got 0x%0h, expected 0x%0h", $time, what, got, exp);
			$display("TEST FAILED");
			$fatal(1, "Value mismatch");
		end
	endtask

	// Called on a falling edge and returns on the next one
	task automatic write_seed(input int start, input int mult);
		seed_i.start = drp_pkg::weight_idx_t'(start);
		seed_i.mult  = drp_pkg::weight_idx_t'(mult);
		seed_we_i    = 1'b1;
		cur_seed     = seed_i;
		@(negedge clk);
		seed_we_i = 1'b0;
	endtask

	task automatic run_request(input int cyc, input int gap, input int hold, input bit wr_hold,
		output drp_pkg::lane_addr_vec_t got);
		int lat;
		drp_pkg::lane_addr_vec_t held;
		repeat (gap) @(negedge clk);
		exp_cycle_q.push_back(cyc);
		exp_seed_q.push_back(cur_seed);
		cycle_idx_i = drp_pkg::cycle_idx_t'(cyc);
		req_i       = 1'b1;
		lat = 0;
		do begin
			@(negedge clk);
			lat++;
		end while (!ack_o && lat < ACK_WAIT_MAX);
		if (!ack_o) begin
			$display("TEST FAILED");
			$fatal(1, "Timed out waiting for ack_o to rise");
		end
		check_value(lat, 2, "falling edges from req_i rise to ack_o rise");
		held = addr_o;
		for (int k = 0; k < hold; k++) begin
			if (wr_hold && k == 0) begin
				write_seed(rand_below(32), rand_below(32) | 1); // Loads while the FSM is in HOLD
			end else begin
				@(negedge clk);
			end
			check_value(addr_o, held, "addr_o changed while req_i was held");
		end
		got   = addr_o;
		req_i = 1'b0;
		lat = 0;
		do begin
			@(negedge clk);
			lat++;
		end while (ack_o && lat < ACK_WAIT_MAX);
		if (ack_o) begin
			$display("TEST FAILED");
			$fatal(1, "Timed out waiting for ack_o to fall");
		end
		check_value(lat, 1, "falling edges from req_i fall to ack_o fall");
	endtask

	// Compares every new answer against the reference
	always @(negedge clk) begin : compare_proc
		int cyc;
		junction_pkg::drp_seed_t sd;
		if (ack_o && !ack_seen) begin
			check_value(exp_cycle_q.size() != 0, 1, "ack_o rose with no request pending");
			cyc = exp_cycle_q.pop_front();
			sd  = exp_seed_q.pop_front();
			for (int k = 0; k < `DRP_Z; k++) begin
				check_value(addr_o[k], ref_neuron(cyc, k, sd.start, sd.mult),
					$sformatf("lane %0d address for cycle %0d", k, cyc));
			end
		end
		ack_seen = ack_o;
	end

	always @(negedge clk) begin
		if (drp_addr_gen_inst.checker_inst.assert_fail_cnt != 0) begin
			$display("TEST FAILED");
			$fatal(1, "The bound checker reported a failed assertion");
		end
	end

	initial begin : watchdog_proc
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("TEST FAILED");
		$fatal(1, "Timeout, the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
	end

	initial begin : main_proc
		drp_pkg::lane_addr_vec_t got;
		int use_cnt[`DRP_P];
		arst_n_i    = 1'b0;
		seed_we_i   = 1'b0;
		seed_i      = '0;
		req_i       = 1'b0;
		cycle_idx_i = '0;
		cur_seed.start = drp_pkg::weight_idx_t'(`DRP_SEED_S_RST);
		cur_seed.mult  = drp_pkg::weight_idx_t'(`DRP_SEED_P_RST);
		repeat (3) @(negedge clk);
		arst_n_i = 1'b1;
		@(negedge clk);

		check_value(ack_o, 0, "ack_o after reset");
		check_value(addr_o, 0, "addr_o after reset");
		check_value(drp_addr_gen_inst.seed.start, `DRP_SEED_S_RST, "start offset after reset");
		check_value(drp_addr_gen_inst.seed.mult, `DRP_SEED_P_RST, "multiplier after reset");
		for (int c = 0; c < 4; c++) run_request(c, 0, 0, 1'b0, got);

		// Each neuron must appear FO times over the four cycles of a junction
		for (int t = 0; t < 6; t++) begin
			write_seed(rand_below(32), rand_below(32) | 1);
			for (int n = 0; n < `DRP_P; n++) use_cnt[n] = 0;
			for (int c = 0; c < 4; c++) begin
				run_request(c, rand_below(4), 0, 1'b0, got);
				for (int k = 0; k < `DRP_Z; k++) use_cnt[got[k]]++;
			end
			for (int n = 0; n < `DRP_P; n++) begin
				check_value(use_cnt[n], `DRP_FO, $sformatf("use count of neuron %0d", n));
			end
		end

		for (int t = 0; t < 20; t++) begin
			if (rand_below(2) == 1) write_seed(rand_below(32), rand_below(32) | 1);
			run_request(rand_below(4), rand_below(4), 0, 1'b0, got);
		end

		for (int t = 0; t < 10; t++) begin
			run_request(rand_below(4), rand_below(4), 1 + rand_below(3), 1'b1, got);
		end

		repeat (2) @(negedge clk);
		if (drp_addr_gen_inst.checker_inst.assert_fail_cnt == 0) begin
			$display("TEST PASSED");
			$finish;
		end else begin
			$display("TEST FAILED");
			$fatal(1, "The bound checker reported a failed assertion");
		end
	end

endmodule

`default_nettype wire

/* src.f */
+incdir+rtl
rtl/drp_pkg.sv
rtl/junction_pkg.sv
rtl/drp_seed_regs.sv
rtl/drp_lane.sv
rtl/drp_req_ctrl.sv
rtl/drp_addr_gen.sv
dv/drp_addr_gen_checker.sv
dv/drp_addr_gen_tb.sv

/* Bender.yml */
package:
  name: drp_addr_gen

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/drp_pkg.sv
      - rtl/junction_pkg.sv
      - rtl/drp_seed_regs.sv
      - rtl/drp_lane.sv
      - rtl/drp_req_ctrl.sv
      - rtl/drp_addr_gen.sv

  - target: simulation
    include_dirs:
      - rtl
    files:
      - dv/drp_addr_gen_checker.sv
      - dv/drp_addr_gen_tb.sv
